/* conv35.f */
+incdir+include
verilog/conv_pkg.sv
verilog/coef_bank.sv
verilog/mac_array.sv
verilog/result_fifo.sv
verilog/conv_top.sv
verif/tb_conv.sv

/* Makefile */
SRCS := $(filter-out +%,$(shell cat conv35.f)) include/tb_conv_model.svh

.PHONY: all run clean

all: obj_dir/Vtb_conv

obj_dir/Vtb_conv: $(SRCS) conv35.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_conv \
		-f conv35.f -o Vtb_conv

run: obj_dir/Vtb_conv
	./obj_dir/Vtb_conv | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/tb_conv_model.svh */
// conv35 reference model and scoreboard queues, included inside the testbench module
`ifndef TB_CONV_MODEL_SVH
`define TB_CONV_MODEL_SVH

conv_pkg::coef_t model_coefs [conv_pkg::NUM_TAPS];  // shadow of the coefficient bank
conv_pkg::res_t  model_fifo [$];                     // expected FIFO contents, oldest first
conv_pkg::res_t  model_pend_res [$];                 // results still inside the pipeline
int              model_pend_due [$];                 // edge at which each reaches the FIFO
int              model_drops;

function automatic void model_reset();
    foreach (model_coefs[i]) begin
        model_coefs[i] = '0;
    end
    model_fifo.delete();
    model_pend_res.delete();
    model_pend_due.delete();
    model_drops = 0;
endfunction

function automatic void model_write_coef(input conv_pkg::coef_addr_t a, input conv_pkg::coef_t d);
    if (a < conv_pkg::NUM_TAPS) begin
        model_coefs[a] = d;
    end
endfunction

function automatic conv_pkg::res_t model_round(input conv_pkg::acc_t sum);
    conv_pkg::acc_t t;
    t = sum;
    if (t < 0) begin
        t = t + conv_pkg::ROUND_BIAS;
    end
    t = t >>> conv_pkg::ROUND_SHIFT;
    return t[conv_pkg::RES_W-1:0];
endfunction

function automatic conv_pkg::res_t model_compute(
    input conv_pkg::samp_t [conv_pkg::NUM_TAPS-1:0] window
);
    conv_pkg::acc_t acc;
    acc = '0;
    for (int i = 0; i < conv_pkg::NUM_TAPS; i++) begin
        acc = acc + conv_pkg::acc_t'(model_coefs[i]) * conv_pkg::acc_t'($signed(window[i]));
    end
    return model_round(acc);
endfunction

// call on the edge that accepts the window, with that edge's number
function automatic void model_push_window(
    input conv_pkg::samp_t [conv_pkg::NUM_TAPS-1:0] window,
    input int cycle
);
    model_pend_res.push_back(model_compute(window));
    model_pend_due.push_back(cycle + conv_pkg::PIPE_LATENCY);
endfunction

// once per edge, pop is pushout && !stopout sampled at that edge
function automatic void model_edge(input int cycle, input bit pop);
    if (pop && model_fifo.size() > 0) begin
        void'(model_fifo.pop_front());
    end
    if (model_pend_due.size() > 0 && model_pend_due[0] == cycle) begin
        void'(model_pend_due.pop_front());
        if (model_fifo.size() < conv_pkg::FIFO_DEPTH) begin
            model_fifo.push_back(model_pend_res.pop_front());
        end else begin
            void'(model_pend_res.pop_front());
            model_drops++;
        end
    end
endfunction

`endif

/* verif/tb_conv.sv */
// self-checking testbench for conv_top; random windows and coefficients against the included model
`timescale 1ns/1ps

module tb_conv;
    import conv_pkg::*;

    typedef samp_t [NUM_TAPS-1:0] window_t;

    // reset, idle, coef test, back-to-back, random stop, fill and drop
    localparam int TEST_CYCLES = 4 + 10 + 110 + 30 + 230 + 50;
    localparam int MAX_CYCLES  = TEST_CYCLES + 100;

    logic       clk;
    logic       reset;
    logic       cw;
    coef_addr_t ca;
    coef_t      cd;
    logic       push_samp;
    window_t    samp;
    logic       stopout;
    logic       pushout;
    res_t       res;

    integer seed;
    int     cycle_count;
    int     edge_num;     // number of the next rising edge after reset
    int     checks;
    int     errors;
    int     tests_run;
    int     test_errors0;
    string  test_name;
    int     pushes_total;
    int     pops_total;

    `include "tb_conv_model.svh"

    conv_top DUT (
        .clk       (clk),
        .reset     (reset),
        .cw        (cw),
        .ca        (ca),
        .cd        (cd),
        .push_samp (push_samp),
        .samp      (samp),
        .stopout   (stopout),
        .pushout   (pushout),
        .res       (res)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic coef_t rand_coef();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return coef_t'({hi, lo});
    endfunction

    function automatic window_t full_window();
        window_t w;
        logic [31:0] hi;
        logic [31:0] lo;
        for (int i = 0; i < NUM_TAPS; i++) begin
            hi = $random(seed);
            lo = $random(seed);
            w[i] = samp_t'({hi, lo});
        end
        return w;
    endfunction

    // 24-bit samples keep the shifted sum inside 45 bits, so its sign survives
    function automatic window_t small_window();
        window_t w;
        logic [31:0] r;
        for (int i = 0; i < NUM_TAPS; i++) begin
            r = $random(seed);
            w[i] = samp_t'($signed(r[23:0]));
        end
        return w;
    endfunction

    function automatic window_t negate_window(input window_t w);
        window_t n;
        for (int i = 0; i < NUM_TAPS; i++) begin
            n[i] = -w[i];
        end
        return n;
    endfunction

    task automatic error_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        errors++;
        $display("[ERROR] %s: expected 0x%0h got 0x%0h at edge %0d", name, expected, actual,
                 edge_num - 1);
    endtask

    task automatic check_outputs(input bit hold, input res_t held_res);
        bit exp_out;
        exp_out = (model_fifo.size() > 0);
        checks++;
        if (pushout !== exp_out) begin
            error_value("pushout", 64'(exp_out), 64'(pushout));
        end
        if (exp_out && pushout === 1'b1) begin
            checks++;
            if (res !== model_fifo[0]) begin
                error_value("res", 64'($unsigned(model_fifo[0])), 64'($unsigned(res)));
            end
        end
        if (hold) begin
            checks++;
            if (res !== held_res) begin
                error_value("res (held)", 64'($unsigned(held_res)), 64'($unsigned(res)));
            end
        end
    endtask

    // one rising edge; called at a falling edge with the inputs already driven
    task automatic tick();
        bit   pop;
        bit   hold;
        res_t held_res;
        pop = pushout && !stopout;
        hold = pushout && stopout;
        held_res = res;
        if (push_samp) begin
            model_push_window(samp, edge_num);  // uses coefficients from before this edge
            pushes_total++;
        end
        if (cw) begin
            model_write_coef(ca, cd);
        end
        model_edge(edge_num, pop);
        if (pop) begin
            pops_total++;
        end
        @(posedge clk);
        edge_num++;
        @(negedge clk);
        check_outputs(hold, held_res);
    endtask

    task automatic drain_results(input int max_cycles);
        int n;
        n = 0;
        stopout = 1'b0;
        push_samp = 1'b0;
        cw = 1'b0;
        while ((model_fifo.size() > 0 || model_pend_res.size() > 0) && n < max_cycles) begin
            tick();
            n++;
        end
        if (model_fifo.size() > 0 || model_pend_res.size() > 0) begin
            errors++;
            $display("results still pending after %0d drain cycles", max_cycles);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors0 = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_errors0) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, test_name, errors - test_errors0);
        end
    endtask

    task automatic run_reset_idle();
        begin_test("idle after reset");
        for (int i = 0; i < 10; i++) begin
            tick();
            checks++;
            if (pushout !== 1'b0) begin
                error_value("pushout", 64'h0, 64'(pushout));
            end
        end
        end_test();
    endtask

    task automatic run_coef_windows();
        window_t w;
        int      neg_seen;
        neg_seen = 0;
        begin_test("coefficient writes and rounding");
        cw = 1'b1;
        for (int i = 0; i < NUM_TAPS; i++) begin
            ca = coef_addr_t'(i);
            cd = rand_coef();
            tick();
        end
        for (int a = NUM_TAPS; a < 64; a++) begin  // out of range, must be ignored
            ca = coef_addr_t'(a);
            cd = rand_coef();
            tick();
        end
        cw = 1'b0;
        for (int p = 0; p < 6; p++) begin
            w = small_window();
            samp = w;
            push_samp = 1'b1;
            if (model_compute(w) < 0) begin
                neg_seen++;
            end
            tick();
            samp = negate_window(w);  // opposite sign sum
            if (model_compute(samp) < 0) begin
                neg_seen++;
            end
            tick();
            push_samp = 1'b0;
            tick();
            tick();
        end
        drain_results(20);
        checks++;
        if (neg_seen == 0) begin
            errors++;
            $display("no window with a negative sum was produced");
        end
        end_test();
    endtask

    task automatic run_back_to_back();
        int e0;
        int first_out;
        int pops0;
        first_out = -1;
        pops0 = pops_total;
        e0 = edge_num;
        begin_test("back-to-back windows");
        stopout = 1'b0;
        for (int i = 0; i < 16 + PIPE_LATENCY + 4; i++) begin
            push_samp = (i < 16);
            samp = full_window();
            tick();
            if (first_out < 0 && pushout === 1'b1) begin
                first_out = edge_num - 1;
            end
        end
        push_samp = 1'b0;
        checks++;
        if (first_out - e0 != PIPE_LATENCY) begin
            errors++;
            $display("first result came %0d cycles after its window, expected %0d",
                     first_out - e0, PIPE_LATENCY);
        end
        checks++;
        if (pops_total - pops0 != 16) begin
            errors++;
            $display("%0d results consumed, expected 16", pops_total - pops0);
        end
        drain_results(20);
        end_test();
    endtask

    task automatic run_random_stop();
        int pushes0;
        int pops0;
        int drops0;
        pushes0 = pushes_total;
        pops0 = pops_total;
        drops0 = model_drops;
        begin_test("random stopout");
        for (int i = 0; i < 200; i++) begin
            push_samp = (($random(seed) & 3) == 0);
            stopout = (($random(seed) & 1) != 0);
            samp = full_window();
            tick();
        end
        drain_results(30);
        checks++;
        if (pops_total - pops0 + model_drops - drops0 != pushes_total - pushes0) begin
            errors++;
            $display("results lost or duplicated: %0d pushed, %0d consumed, %0d dropped",
                     pushes_total - pushes0, pops_total - pops0, model_drops - drops0);
        end
        end_test();
    endtask

    task automatic run_fill_drop();
        res_t kept_exp [$];
        int   kept;
        kept = 0;
        begin_test("fill and drop");
        stopout = 1'b1;
        push_samp = 1'b1;
        for (int i = 0; i < 20; i++) begin
            samp = full_window();
            if (i < FIFO_DEPTH) begin
                kept_exp.push_back(model_compute(samp));
            end
            tick();
        end
        push_samp = 1'b0;
        repeat (PIPE_LATENCY + 2) tick();
        stopout = 1'b0;
        // count what the DUT hands out once released
        while (pushout === 1'b1 && kept < 2 * FIFO_DEPTH) begin
            checks++;
            if (kept_exp.size() == 0) begin
                errors++;
                $display("FIFO delivered more than the oldest %0d results", FIFO_DEPTH);
            end else begin
                if (res !== kept_exp[0]) begin
                    error_value("res", 64'($unsigned(kept_exp[0])), 64'($unsigned(res)));
                end
                void'(kept_exp.pop_front());
            end
            kept++;
            tick();
        end
        checks++;
        if (kept != FIFO_DEPTH) begin
            errors++;
            $display("%0d results dropped, expected %0d", 20 - kept, 20 - FIFO_DEPTH);
        end
        drain_results(10);
        end_test();
    endtask

    initial begin
        seed = 32'h5541e25a;
        reset = 1'b1;
        cw = 1'b0;
        ca = '0;
        cd = '0;
        push_samp = 1'b0;
        samp = '0;
        stopout = 1'b0;
        cycle_count = 0;
        edge_num = 0;
        checks = 0;
        errors = 0;
        tests_run = 0;
        pushes_total = 0;
        pops_total = 0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        model_reset();

        run_reset_idle();
        run_coef_windows();
        run_back_to_back();
        run_random_stop();
        run_fill_drop();

        $display("tests %0d, checks %0d, errors %0d, drops %0d", tests_run, checks, errors,
                 model_drops);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verilog/conv_top.sv */
// top level of the conv35 engine, wires coefficient bank, MAC datapath and output FIFO
`timescale 1ns/1ps

module conv_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    cw,
    input  conv_pkg::coef_addr_t                    ca,
    input  conv_pkg::coef_t                         cd,
    input  logic                                    push_samp,
    input  conv_pkg::samp_t [conv_pkg::NUM_TAPS-1:0] samp,
    input  logic                                    stopout,
    output logic                                    pushout,
    output conv_pkg::res_t                          res
);
    import conv_pkg::*;

    coef_t [NUM_TAPS-1:0] coefs;
    logic                 sum_valid;
    res_t                 sum_res;

    coef_bank u_coef_bank (
        .clk   (clk),
        .reset (reset),
        .cw    (cw),
        .ca    (ca),
        .cd    (cd),
        .coefs (coefs)
    );

    mac_array u_mac_array (
        .clk       (clk),
        .reset     (reset),
        .push_samp (push_samp),
        .samp      (samp),
        .coefs     (coefs),
        .sum_valid (sum_valid),
        .sum_res   (sum_res)
    );

    // no stall path back into the pipeline
    result_fifo u_result_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (sum_valid),
        .wr_data  (sum_res),
        .stopout  (stopout),
        .pushout  (pushout),
        .res      (res)
    );

endmodule

/* verilog/result_fifo.sv */
// output FIFO of conv35, first-word fall-through, drops results that arrive when full
`timescale 1ns/1ps

module result_fifo (
    input  logic           clk,
    input  logic           reset,
    input  logic           wr_valid,
    input  conv_pkg::res_t wr_data,
    input  logic           stopout,
    output logic           pushout,
    output conv_pkg::res_t res
);
    import conv_pkg::*;

    res_t mem [FIFO_DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;

    logic full;
    logic push;
    logic pop;

    assign full = (count == fifo_cnt_t'(FIFO_DEPTH));

    // oldest entry always on the output
    assign pushout = (count != '0);
    assign res     = mem[rd_ptr];

    assign pop  = pushout & ~stopout;
    assign push = wr_valid & (~full | pop);  // a same-edge pop frees the slot

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset) count <= fifo_cnt_t'(FIFO_DEPTH)
    );

    // held result must not move while the consumer stalls
    a_res_held: assert property (
        @(posedge clk) disable iff (reset) (pushout && stopout) |=> (pushout && $stable(res))
    );

endmodule

/* verilog/mac_array.sv */
// multiply-accumulate datapath of conv35; window in, one rounded 45-bit result out per window
`timescale 1ns/1ps

module mac_array (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    push_samp,
    input  conv_pkg::samp_t [conv_pkg::NUM_TAPS-1:0] samp,
    input  conv_pkg::coef_t [conv_pkg::NUM_TAPS-1:0] coefs,
    output logic                                    sum_valid,
    output conv_pkg::res_t                          sum_res
);
    import conv_pkg::*;

    samp_t samp_r [NUM_TAPS];
    coef_t coef_r [NUM_TAPS];

    // prod_q[0] is the raw product, later stages only carry it along
    prod_t prod_q [MULT_STAGES][NUM_TAPS];

    acc_t acc_next;
    acc_t acc_q;
    acc_t acc_rnd;
    acc_t acc_shift;
    res_t res_q;

    logic [PIPE_LATENCY-1:0] valid_q;

    // window and coefficients latched together, so a write after
    // the push cannot leak into this window
    always_ff @(posedge clk) begin
        if (push_samp) begin
            for (int t = 0; t < NUM_TAPS; t++) begin
                samp_r[t] <= samp[t];
                coef_r[t] <= coefs[t];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int t = 0; t < NUM_TAPS; t++) begin
            prod_q[0][t] <= coef_r[t] * samp_r[t];  // signed 33 x 40
            for (int s = 1; s < MULT_STAGES; s++) begin
                prod_q[s][t] <= prod_q[s-1][t];
            end
        end
    end

    // adder tree left to synthesis
    always_comb begin
        acc_next = '0;
        for (int t = 0; t < NUM_TAPS; t++) begin
            acc_next = acc_next + acc_t'(prod_q[MULT_STAGES-1][t]);
        end
    end

    always_ff @(posedge clk) begin
        acc_q <= acc_next;
    end

    // negative sums get half an lsb added before the arithmetic shift
    always_comb begin
        acc_rnd = acc_q;
        if (acc_q[ACC_W-1]) begin
            acc_rnd = acc_q + ROUND_BIAS;
        end
        acc_shift = acc_rnd >>> ROUND_SHIFT;
    end

    always_ff @(posedge clk) begin
        res_q <= acc_shift[RES_W-1:0];  // upper bits dropped
    end

    assign sum_res = res_q;

    // one valid bit per data register above
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[PIPE_LATENCY-2:0], push_samp};
        end
    end

    assign sum_valid = valid_q[PIPE_LATENCY-1];

    a_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(valid_q)
    );

endmodule

/* verilog/coef_bank.sv */
// coefficient register file of conv35, loaded one tap per cycle through cw/ca/cd
`timescale 1ns/1ps

module coef_bank (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    cw,
    input  conv_pkg::coef_addr_t                    ca,
    input  conv_pkg::coef_t                         cd,
    output conv_pkg::coef_t [conv_pkg::NUM_TAPS-1:0] coefs
);
    import conv_pkg::*;

    // one decoder per tap, addresses past the last tap hit nothing
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coefs <= '0;
        end else if (cw) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                if (ca == coef_addr_t'(i)) begin
                    coefs[i] <= cd;
                end
            end
        end
    end

    // a floating address would corrupt an arbitrary tap
    a_ca_known: assert property (
        @(posedge clk) disable iff (reset) cw |-> !$isunknown(ca)
    );

endmodule

/* verilog/conv_pkg.sv */
// widths, tap count, latencies and data types shared by the conv35 RTL blocks
package conv_pkg;

    // window geometry, 7 rows of 5
    localparam int NUM_TAPS = 35;

    localparam int COEF_W = 33;
    localparam int SAMP_W = 40;
    localparam int PROD_W = COEF_W + SAMP_W;  // full signed product, 73
    localparam int ACC_W  = 80;               // room for 35 products
    localparam int RES_W  = 45;
    localparam int ADDR_W = 6;

    localparam int ROUND_SHIFT = 25;

    // capture + products + sum + round
    localparam int MULT_STAGES  = 3;
    localparam int PIPE_LATENCY = MULT_STAGES + 3;

    localparam int FIFO_DEPTH = 8;            // power of two, pointers wrap on their own
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [SAMP_W-1:0] samp_t;
    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic signed [RES_W-1:0]  res_t;

    typedef logic [ADDR_W-1:0] coef_addr_t;

    typedef logic [FIFO_AW-1:0] fifo_ptr_t;
    typedef logic [FIFO_AW:0]   fifo_cnt_t;   // one extra bit to tell full from empty

    // added to a negative sum before the arithmetic shift
    localparam acc_t ROUND_BIAS = acc_t'(1) << (ROUND_SHIFT - 1);

endpackage
